/* bench/bpu_assertions.sv */
`timescale 1ns/1ns

module bpu_assertions (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input bpu_pkg::handshake_t  hs_i,
  input logic                 flush_i,
  input bpu_pkg::bpu_to_ifu_t resp_i
);

  logic accept;

  assign accept = hs_i.valid && hs_i.ready;

  // one response per accepted request, none under flush.
  a_valid_after_accept : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.pred_valid |-> $past(accept && !flush_i) && !flush_i)
    else $error("pred_valid high without an unflushed accept one cycle before");

  a_slot_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.pred_slot_valid |-> resp_i.pred_valid)
    else $error("pred_slot_valid high while pred_valid is low");

  a_quiet_in_reset : assert property (@(posedge clk_i)
    !rst_n_i |-> !resp_i.pred_valid && !resp_i.pred_slot_valid)
    else $error("response valid bits high during reset");

endmodule

bind bpu bpu_assertions u_bpu_assertions (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .hs_i    (ifu_to_bpu_handshake_i),
  .flush_i (flush_i),
  .resp_i  (bpu_to_ifu_o)
);

/* bench/bpu_patterns.txt */
# U pc is_cond taken target is_call is_ret
# P ready pc flush then expected pred_valid npc slot_valid slot_idx slot_target ghr
# cold tables fall through to the next block
P 1 00001000 0 1 00001010 0 0 00000000 00
P 1 00001008 0 1 00001010 0 0 00000000 00
# taken updates on slot 1 until the history saturates at ff
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
U 00002004 1 1 00003000 0 0
P 1 00002000 0 1 00003000 1 1 00003000 ff
P 1 00002008 0 1 00002010 0 0 00000000 ff
U 00002004 1 0 00003000 0 0
P 1 00002000 0 1 00002010 0 0 00000000 fe
# jumps in slots 1 and 3
U 00004044 0 1 00005000 0 0
U 0000404c 0 1 00006000 0 0
P 1 00004040 0 1 00005000 1 1 00005000 fe
P 1 00004048 0 1 00006000 1 3 00006000 fe
# return entry, then nested calls
U 00008010 0 1 0000aaa0 0 1
U 00007000 0 1 00008000 1 0
P 1 00008010 0 1 00007004 1 0 00007004 fe
U 00009008 0 1 00008000 1 0
P 1 00008010 0 1 0000900c 1 0 0000900c fe
U 00008010 0 1 0000aaa0 0 1
P 1 00008010 0 1 00007004 1 0 00007004 fe
U 00008010 0 1 0000aaa0 0 1
P 1 00008010 0 1 0000aaa0 1 0 0000aaa0 fe
# ready low, then flush, then a clean request
P 0 00004040 0 0 00000000 0 0 00000000 fe
P 1 00004040 1 0 00000000 0 0 00000000 fe
P 1 00004040 0 1 00005000 1 1 00005000 fe
# counter trained by a020 at history fd is read by a038 at history fb
U 0000a038 1 1 0000b000 0 0
U 0000a020 1 1 0000c000 0 0
P 1 0000a020 0 1 0000a030 0 0 00000000 fb
P 1 0000a030 0 1 0000b000 1 2 0000b000 fb

/* bench/bpu_tb.sv */
`timescale 1ns/1ns

module bpu_tb;

  localparam string PATTERN_FILE = "bench/bpu_patterns.txt";

  logic        clk;
  logic        rst_n;
  logic        ifu_valid;
  logic        ifu_ready;
  logic [31:0] pc;
  logic        upd_valid;
  logic [31:0] upd_pc;
  logic        upd_is_cond;
  logic        upd_taken;
  logic [31:0] upd_target;
  logic        upd_is_call;
  logic        upd_is_ret;
  logic        flush;
  logic        pred_valid;
  logic [31:0] npc;
  logic        pred_slot_valid;
  logic [1:0]  pred_slot_idx;
  logic [31:0] pred_slot_target;
  logic [7:0]  dbg_ghr;

  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;  // zero until the patterns are counted.
  int          line_no = 0;

  bpu_wrap u_dut (
    .clk_i              (clk),
    .rst_n_i            (rst_n),
    .ifu_valid_i        (ifu_valid),
    .ifu_ready_i        (ifu_ready),
    .pc_i               (pc),
    .update_valid_i     (upd_valid),
    .update_pc_i        (upd_pc),
    .update_is_cond_i   (upd_is_cond),
    .update_taken_i     (upd_taken),
    .update_target_i    (upd_target),
    .update_is_call_i   (upd_is_call),
    .update_is_ret_i    (upd_is_ret),
    .flush_i            (flush),
    .pred_valid_o       (pred_valid),
    .npc_o              (npc),
    .pred_slot_valid_o  (pred_slot_valid),
    .pred_slot_idx_o    (pred_slot_idx),
    .pred_slot_target_o (pred_slot_target),
    .dbg_ghr_o          (dbg_ghr)
  );

  task automatic give_up(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h (pattern line %0d)",
               name, got, exp, line_no);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      give_up($sformatf("timeout: patterns still running after %0d cycles", cycles));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pattern player
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int               fd;
    int               code;
    int               n_lines;
    logic [7:0]       cmd;
    logic [8*160-1:0] text;
    logic [31:0]      f_pc, f_cond, f_taken, f_target, f_call, f_ret, f_ready, f_flush;
    logic [31:0]      e_pv, e_npc, e_sv, e_idx, e_tgt, e_ghr;

    rst_n       = 1'b0;
    ifu_valid   = 1'b0;
    ifu_ready   = 1'b0;
    pc          = '0;
    upd_valid   = 1'b0;
    upd_pc      = '0;
    upd_is_cond = 1'b0;
    upd_taken   = 1'b0;
    upd_target  = '0;
    upd_is_call = 1'b0;
    upd_is_ret  = 1'b0;
    flush       = 1'b0;

    n_lines = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) give_up("cannot open the pattern file");
    while ($fgets(text, fd) != 0) begin
      n_lines++;
    end
    $fclose(fd);
    cycle_limit = 4 * n_lines + 20;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen(PATTERN_FILE, "r");
    while ($fscanf(fd, "%s", cmd) == 1) begin
      line_no++;
      if (cmd == "#") begin
        code = $fgets(text, fd);
      end else if (cmd == "U") begin
        code = $fscanf(fd, "%h %h %h %h %h %h", f_pc, f_cond, f_taken, f_target, f_call, f_ret);
        if (code != 6) give_up($sformatf("malformed update on pattern line %0d", line_no));
        upd_valid   = 1'b1;
        upd_pc      = f_pc;
        upd_is_cond = f_cond[0];
        upd_taken   = f_taken[0];
        upd_target  = f_target;
        upd_is_call = f_call[0];
        upd_is_ret  = f_ret[0];
        @(negedge clk);
        upd_valid = 1'b0;
      end else if (cmd == "P") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f_ready, f_pc, f_flush,
                       e_pv, e_npc, e_sv, e_idx, e_tgt, e_ghr);
        if (code != 9) give_up($sformatf("malformed predict on pattern line %0d", line_no));
        ifu_valid = 1'b1;
        ifu_ready = f_ready[0];
        pc        = f_pc;
        flush     = f_flush[0];
        @(negedge clk);  // response cycle, flush still held.
        check_value("pred_valid", 32'(pred_valid), e_pv);
        check_value("pred_slot_valid", 32'(pred_slot_valid), e_sv);
        check_value("dbg_ghr", 32'(dbg_ghr), e_ghr);
        if (e_pv[0]) check_value("npc", npc, e_npc);
        if (e_sv[0]) begin
          check_value("pred_slot_idx", 32'(pred_slot_idx), e_idx);
          check_value("pred_slot_target", pred_slot_target, e_tgt);
        end
        ifu_valid = 1'b0;
        ifu_ready = 1'b0;
        flush     = 1'b0;
      end else begin
        give_up($sformatf("unknown command on pattern line %0d", line_no));
      end
    end
    $fclose(fd);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* flist.f */
hw/bpu_pkg.sv
hw/btb.sv
hw/bht.sv
hw/ras.sv
hw/bpu.sv
hw/bpu_wrap.sv
bench/bpu_assertions.sv
bench/bpu_tb.sv

/* hw/bht.sv */
`timescale 1ns/1ns

module bht #(
  parameter int unsigned ENTRIES     = 512,
  parameter bit          HASH_ENABLE = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  bpu_pkg::addr_t                      lookup_pc_i,
  input  bpu_pkg::ghr_t                       ghr_i,
  output logic [bpu_pkg::INSTR_PER_FETCH-1:0] taken_o,
  input  bpu_pkg::bpu_update_t                upd_i
);

  localparam int unsigned IDX_BITS = $clog2(ENTRIES);

  typedef logic [IDX_BITS-1:0] idx_t;

  logic [1:0] ctr_q [ENTRIES];
  idx_t       upd_idx;

  // word address, optionally folded with the history.
  function automatic idx_t index_of(bpu_pkg::addr_t pc, bpu_pkg::ghr_t ghr);
    idx_t idx;
    idx = pc[2 +: IDX_BITS];
    if (HASH_ENABLE) begin
      idx = idx ^ idx_t'(ghr);
    end
    return idx;
  endfunction

  always_comb begin
    bpu_pkg::addr_t slot_pc;
    for (int s = 0; s < bpu_pkg::INSTR_PER_FETCH; s++) begin
      slot_pc = {lookup_pc_i[bpu_pkg::XLEN-1:bpu_pkg::BLOCK_OFFSET_BITS],
                 bpu_pkg::BLOCK_OFFSET_BITS'(0)} + bpu_pkg::addr_t'(s * bpu_pkg::INSTR_BYTES);
      taken_o[s] = ctr_q[index_of(slot_pc, ghr_i)][1];  // msb is the prediction.
    end
  end

  assign upd_idx = index_of(upd_i.pc, ghr_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ENTRIES; i++) begin
        ctr_q[i] <= 2'b01;  // weakly not taken.
      end
    end else if (upd_i.valid && upd_i.is_cond) begin
      if (upd_i.taken && ctr_q[upd_idx] != 2'b11) begin
        ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'b01;
      end else if (!upd_i.taken && ctr_q[upd_idx] != 2'b00) begin
        ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'b01;
      end
    end
  end

endmodule

/* hw/bpu.sv */
`timescale 1ns/1ns

module bpu #(
  parameter int unsigned BTB_ENTRIES     = 128,
  parameter int unsigned BHT_ENTRIES     = 512,
  parameter int unsigned RAS_DEPTH       = 8,
  parameter bit          BHT_HASH_ENABLE = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  bpu_pkg::handshake_t  ifu_to_bpu_handshake_i,
  input  bpu_pkg::ifu_to_bpu_t ifu_to_bpu_i,
  input  bpu_pkg::bpu_update_t update_i,
  input  logic                 flush_i,
  output bpu_pkg::bpu_to_ifu_t bpu_to_ifu_o,
  output bpu_pkg::ghr_t        dbg_ghr_o
);

  localparam int unsigned NSLOT = bpu_pkg::INSTR_PER_FETCH;

  logic [NSLOT-1:0]                    btb_hit_vec;
  bpu_pkg::br_kind_t [NSLOT-1:0]       btb_kind;
  bpu_pkg::addr_t [NSLOT-1:0]          btb_target;
  logic [NSLOT-1:0]                    bht_taken;
  bpu_pkg::addr_t                      ras_top;
  logic                                ras_valid;

  bpu_pkg::ghr_t                       ghr_q;
  logic                                accept;
  bpu_pkg::slot_idx_t                  start_slot;
  bpu_pkg::addr_t                      block_base;
  logic [NSLOT-1:0]                    slot_taken;
  bpu_pkg::addr_t [NSLOT-1:0]          slot_target;
  logic                                sel_valid;
  bpu_pkg::slot_idx_t                  sel_idx;
  bpu_pkg::addr_t                      sel_target;

  logic                                pred_valid_q;
  logic                                slot_valid_q;
  bpu_pkg::addr_t                      npc_q;
  bpu_pkg::slot_idx_t                  slot_idx_q;
  bpu_pkg::addr_t                      slot_target_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tables
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  btb #(.ENTRIES(BTB_ENTRIES)) u_btb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (ifu_to_bpu_i.pc),
    .hit_o       (btb_hit_vec),
    .kind_o      (btb_kind),
    .target_o    (btb_target),
    .upd_i       (update_i)
  );

  bht #(.ENTRIES(BHT_ENTRIES), .HASH_ENABLE(BHT_HASH_ENABLE)) u_bht (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (ifu_to_bpu_i.pc),
    .ghr_i       (ghr_q),
    .taken_o     (bht_taken),
    .upd_i       (update_i)
  );

  ras #(.DEPTH(RAS_DEPTH)) u_ras (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .upd_i   (update_i),
    .top_o   (ras_top),
    .valid_o (ras_valid)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slot selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign accept     = ifu_to_bpu_handshake_i.valid && ifu_to_bpu_handshake_i.ready;
  assign start_slot = ifu_to_bpu_i.pc[2 +: bpu_pkg::SLOT_BITS];
  assign block_base = {ifu_to_bpu_i.pc[bpu_pkg::XLEN-1:bpu_pkg::BLOCK_OFFSET_BITS],
                       bpu_pkg::BLOCK_OFFSET_BITS'(0)};

  always_comb begin
    for (int s = 0; s < NSLOT; s++) begin
      slot_taken[s] = btb_hit_vec[s]
                      && (bpu_pkg::slot_idx_t'(s) >= start_slot)
                      && (btb_kind[s] != bpu_pkg::BR_COND || bht_taken[s]);
      // returns take the stack top while it holds something.
      if (btb_kind[s] == bpu_pkg::BR_RET && ras_valid) begin
        slot_target[s] = ras_top;
      end else begin
        slot_target[s] = btb_target[s];
      end
    end
  end

  // walk down so the lowest taken slot is left standing.
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int s = NSLOT - 1; s >= 0; s--) begin
      if (slot_taken[s]) begin
        sel_valid = 1'b1;
        sel_idx   = bpu_pkg::slot_idx_t'(s);
      end
    end
  end

  assign sel_target = slot_target[sel_idx];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response and history registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pred_valid_q <= 1'b0;
      slot_valid_q <= 1'b0;
      ghr_q        <= '0;
    end else begin
      pred_valid_q <= accept && !flush_i;
      slot_valid_q <= accept && !flush_i && sel_valid;
      if (update_i.valid && update_i.is_cond) begin
        ghr_q <= {ghr_q[bpu_pkg::GHR_BITS-2:0], update_i.taken};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      npc_q         <= sel_valid ? sel_target
                                 : block_base + bpu_pkg::addr_t'(bpu_pkg::FETCH_BYTES);
      slot_idx_q    <= sel_idx;
      slot_target_q <= sel_target;
    end
  end

  // a late flush still kills the response.
  always_comb begin
    bpu_to_ifu_o.pred_valid       = pred_valid_q && !flush_i;
    bpu_to_ifu_o.npc              = npc_q;
    bpu_to_ifu_o.pred_slot_valid  = slot_valid_q && !flush_i;
    bpu_to_ifu_o.pred_slot_idx    = slot_idx_q;
    bpu_to_ifu_o.pred_slot_target = slot_target_q;
  end

  assign dbg_ghr_o = ghr_q;

endmodule

/* hw/bpu_pkg.sv */
package bpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and fetch geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned XLEN = 32;
  localparam int unsigned INSTR_BYTES = 4;
  localparam int unsigned INSTR_PER_FETCH = 4;
  localparam int unsigned SLOT_BITS = $clog2(INSTR_PER_FETCH);
  localparam int unsigned FETCH_BYTES = INSTR_PER_FETCH * INSTR_BYTES;  // 16 byte block.
  localparam int unsigned BLOCK_OFFSET_BITS = $clog2(FETCH_BYTES);
  localparam int unsigned GHR_BITS = 8;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [SLOT_BITS-1:0] slot_idx_t;
  typedef logic [GHR_BITS-1:0] ghr_t;

  // branch kind held in the btb.
  typedef logic [1:0] br_kind_t;

  localparam br_kind_t BR_COND = 2'd0;
  localparam br_kind_t BR_JUMP = 2'd1;
  localparam br_kind_t BR_CALL = 2'd2;
  localparam br_kind_t BR_RET = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request, response and update
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    addr_t pc;
  } ifu_to_bpu_t;

  typedef struct packed {
    logic valid;
    logic ready;
  } handshake_t;

  typedef struct packed {
    logic      pred_valid;
    addr_t     npc;
    logic      pred_slot_valid;
    slot_idx_t pred_slot_idx;
    addr_t     pred_slot_target;
  } bpu_to_ifu_t;

  // one resolved branch from the backend.
  typedef struct packed {
    logic  valid;
    addr_t pc;
    logic  is_cond;
    logic  taken;
    addr_t target;
    logic  is_call;
    logic  is_ret;
  } bpu_update_t;

endpackage

/* hw/bpu_wrap.sv */
`timescale 1ns/1ns

module bpu_wrap #(
  parameter int unsigned BTB_ENTRIES     = 128,
  parameter int unsigned BHT_ENTRIES     = 512,
  parameter int unsigned RAS_DEPTH       = 8,
  parameter bit          BHT_HASH_ENABLE = 1'b1
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // fetch request.
  input  logic                       ifu_valid_i,
  input  logic                       ifu_ready_i,
  input  bpu_pkg::addr_t             pc_i,
  // resolved branch.
  input  logic                       update_valid_i,
  input  bpu_pkg::addr_t             update_pc_i,
  input  logic                       update_is_cond_i,
  input  logic                       update_taken_i,
  input  bpu_pkg::addr_t             update_target_i,
  input  logic                       update_is_call_i,
  input  logic                       update_is_ret_i,
  input  logic                       flush_i,
  // prediction.
  output logic                       pred_valid_o,
  output bpu_pkg::addr_t             npc_o,
  output logic                       pred_slot_valid_o,
  output bpu_pkg::slot_idx_t         pred_slot_idx_o,
  output bpu_pkg::addr_t             pred_slot_target_o,
  output bpu_pkg::ghr_t              dbg_ghr_o
);

  bpu_pkg::handshake_t  ifu_hs;
  bpu_pkg::ifu_to_bpu_t ifu_req;
  bpu_pkg::bpu_update_t upd;
  bpu_pkg::bpu_to_ifu_t resp;

  assign ifu_hs.valid = ifu_valid_i;
  assign ifu_hs.ready = ifu_ready_i;
  assign ifu_req.pc   = pc_i;

  assign upd.valid   = update_valid_i;
  assign upd.pc      = update_pc_i;
  assign upd.is_cond = update_is_cond_i;
  assign upd.taken   = update_taken_i;
  assign upd.target  = update_target_i;
  assign upd.is_call = update_is_call_i;
  assign upd.is_ret  = update_is_ret_i;

  bpu #(
    .BTB_ENTRIES     (BTB_ENTRIES),
    .BHT_ENTRIES     (BHT_ENTRIES),
    .RAS_DEPTH       (RAS_DEPTH),
    .BHT_HASH_ENABLE (BHT_HASH_ENABLE)
  ) u_bpu (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .ifu_to_bpu_handshake_i (ifu_hs),
    .ifu_to_bpu_i           (ifu_req),
    .update_i               (upd),
    .flush_i                (flush_i),
    .bpu_to_ifu_o           (resp),
    .dbg_ghr_o              (dbg_ghr_o)
  );

  assign pred_valid_o       = resp.pred_valid;
  assign npc_o              = resp.npc;
  assign pred_slot_valid_o  = resp.pred_slot_valid;
  assign pred_slot_idx_o    = resp.pred_slot_idx;
  assign pred_slot_target_o = resp.pred_slot_target;

endmodule

/* hw/btb.sv */
`timescale 1ns/1ns

module btb #(
  parameter int unsigned ENTRIES = 128
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  bpu_pkg::addr_t                                       lookup_pc_i,
  output logic [bpu_pkg::INSTR_PER_FETCH-1:0]                  hit_o,
  output bpu_pkg::br_kind_t [bpu_pkg::INSTR_PER_FETCH-1:0]     kind_o,
  output bpu_pkg::addr_t [bpu_pkg::INSTR_PER_FETCH-1:0]        target_o,
  input  bpu_pkg::bpu_update_t                                 upd_i
);

  localparam int unsigned BANKS = bpu_pkg::INSTR_PER_FETCH;
  localparam int unsigned SETS = ENTRIES / BANKS;
  localparam int unsigned IDX_BITS = $clog2(SETS);
  localparam int unsigned TAG_BITS = bpu_pkg::XLEN - bpu_pkg::BLOCK_OFFSET_BITS - IDX_BITS;

  typedef logic [IDX_BITS-1:0] idx_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  typedef struct packed {
    tag_t              tag;
    bpu_pkg::br_kind_t kind;
    bpu_pkg::addr_t    target;
  } entry_t;

  logic [BANKS-1:0][SETS-1:0] valid_q;
  entry_t                     mem_q [BANKS][SETS];

  idx_t                  lkp_idx;
  tag_t                  lkp_tag;
  idx_t                  upd_idx;
  bpu_pkg::slot_idx_t    upd_bank;
  logic                  upd_we;
  entry_t                upd_entry;

  // same set in every bank, bank s serves slot s.
  assign lkp_idx = lookup_pc_i[bpu_pkg::BLOCK_OFFSET_BITS +: IDX_BITS];
  assign lkp_tag = lookup_pc_i[bpu_pkg::XLEN-1 -: TAG_BITS];

  always_comb begin
    for (int s = 0; s < BANKS; s++) begin
      hit_o[s]    = valid_q[s][lkp_idx] && (mem_q[s][lkp_idx].tag == lkp_tag);
      kind_o[s]   = mem_q[s][lkp_idx].kind;
      target_o[s] = mem_q[s][lkp_idx].target;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // update path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign upd_idx  = upd_i.pc[bpu_pkg::BLOCK_OFFSET_BITS +: IDX_BITS];
  assign upd_bank = upd_i.pc[2 +: bpu_pkg::SLOT_BITS];  // slot of the branch.
  assign upd_we   = upd_i.valid && (upd_i.taken || !upd_i.is_cond);

  always_comb begin
    upd_entry.tag    = upd_i.pc[bpu_pkg::XLEN-1 -: TAG_BITS];
    upd_entry.target = upd_i.target;
    if (upd_i.is_ret) begin
      upd_entry.kind = bpu_pkg::BR_RET;
    end else if (upd_i.is_call) begin
      upd_entry.kind = bpu_pkg::BR_CALL;
    end else if (upd_i.is_cond) begin
      upd_entry.kind = bpu_pkg::BR_COND;
    end else begin
      upd_entry.kind = bpu_pkg::BR_JUMP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (upd_we) begin
      valid_q[upd_bank][upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_we) begin
      mem_q[upd_bank][upd_idx] <= upd_entry;
    end
  end

endmodule

/* hw/ras.sv */
`timescale 1ns/1ns

module ras #(
  parameter int unsigned DEPTH = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  bpu_pkg::bpu_update_t upd_i,
  output bpu_pkg::addr_t       top_o,
  output logic                 valid_o
);

  localparam int unsigned PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_BITS = $clog2(DEPTH + 1);

  typedef logic [PTR_BITS-1:0] ptr_t;
  typedef logic [CNT_BITS-1:0] cnt_t;

  bpu_pkg::addr_t stack_q [DEPTH];
  ptr_t           ptr_q;  // next free slot.
  cnt_t           cnt_q;
  ptr_t           ptr_inc;
  ptr_t           ptr_dec;
  logic           push;
  logic           pop;

  assign ptr_inc = (ptr_q == ptr_t'(DEPTH - 1)) ? '0 : ptr_q + ptr_t'(1);
  assign ptr_dec = (ptr_q == '0) ? ptr_t'(DEPTH - 1) : ptr_q - ptr_t'(1);

  assign push = upd_i.valid && upd_i.is_call;
  assign pop  = upd_i.valid && upd_i.is_ret && !upd_i.is_call && (cnt_q != '0);

  assign top_o   = stack_q[ptr_dec];
  assign valid_o = (cnt_q != '0);

  // pointer wraps, so a push on a full stack drops the oldest.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
      cnt_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_inc;
      if (cnt_q != cnt_t'(DEPTH)) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end
    end else if (pop) begin
      ptr_q <= ptr_dec;
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      stack_q[ptr_q] <= upd_i.pc + bpu_pkg::addr_t'(bpu_pkg::INSTR_BYTES);  // return address.
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module bpu_tb -Mdir obj_dir -f flist.f

output=$(./obj_dir/Vbpu_tb 2>&1 || true)
echo "$output"

if grep -qx "Simulation PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
